// File: Bender.yml
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - inst_fetch.sv
  - inst_decoder.sv
  - ex_alu.sv
  - ex_branch.sv
  - mem_access.sv
  - registers.sv
  - cpu_pipeline.sv
  - target: test
    files:
      - tb_clock.sv
      - cpu_assertions.sv
      - tb_cpu.sv

// File: cpu.f
cpu_pkg.sv
inst_fetch.sv
inst_decoder.sv
ex_alu.sv
ex_branch.sv
mem_access.sv
registers.sv
cpu_pipeline.sv
tb_clock.sv
cpu_assertions.sv
tb_cpu.sv

// File: cpu_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port assertions for the core
// data command hold, request idle at reset,
// word aligned fetch, bind to the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cpu_assertions (
    input logic               clk,
    input logic               rst,
    input cpu_pkg::xlen_t     imem_addr,
    input logic               dmem_req,
    input cpu_pkg::dmem_cmd_t dmem_cmd,
    input logic               dmem_ready
);

    // read by the testbench top
    int unsigned fail_count = 0;

    // command may not move until ready is seen
    cmd_held: assert property (@(posedge clk) disable iff (!rst)
        dmem_req && !dmem_ready |=> $stable(dmem_cmd))
    else begin
        fail_count++;
        $error("dmem_cmd changed while dmem_req waited for dmem_ready");
    end

    req_idle_at_reset: assert property (@(posedge clk)
        (!rst || $rose(rst)) |-> !dmem_req)
    else begin
        fail_count++;
        $error("dmem_req high during or right after reset");
    end

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst)
        imem_addr[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("imem_addr not word aligned");
    end

endmodule

bind cpu_pipeline cpu_assertions u_assert (
    .clk(clk),
    .rst(rst),
    .imem_addr(imem_addr),
    .dmem_req(dmem_req),
    .dmem_cmd(dmem_cmd),
    .dmem_ready(dmem_ready)
);

// File: cpu_pipeline.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// three-stage core top: fetch, decode, execute/wb
// IF/ID and ID/EX registers, stall and flush
// write-back select, load > link > ALU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module cpu_pipeline #(
    parameter cpu_pkg::xlen_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rst,
    output cpu_pkg::xlen_t     imem_addr,
    input  cpu_pkg::inst_t     imem_data,
    output logic               dmem_req,
    output cpu_pkg::dmem_cmd_t dmem_cmd,
    input  cpu_pkg::xlen_t     dmem_rdata,
    input  logic               dmem_ready
);
    import cpu_pkg::*;

    xlen_t     pc;
    logic      if_id_valid;
    xlen_t     if_id_pc;
    inst_t     if_id_inst;
    decoded_t  id_dec;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    id_ex_t    id_ex;
    xlen_t     alu_b;
    xlen_t     alu_result;
    logic      taken;
    xlen_t     br_target;
    xlen_t     link;
    logic      mem_stall;
    logic      load_valid;
    xlen_t     load_data;
    logic      wb_en;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    inst_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .stall(mem_stall),
        .jump_en(taken),
        .jump_target(br_target),
        .pc(pc)
    );

    // instruction port answers in the same cycle
    assign imem_addr = pc;

    inst_decoder u_decoder (
        .inst(if_id_inst),
        .dec(id_dec)
    );

    registers u_regs (
        .clk(clk),
        .rst(rst),
        .rs1(id_dec.rs1),
        .rs2(id_dec.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb_en(wb_en),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    // IF/ID and ID/EX: flush on taken, hold on stall
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            if_id_valid <= 1'b0;
            if_id_pc    <= '0;
            if_id_inst  <= '0;
            id_ex       <= '0;
        end else if (taken) begin
            if_id_valid <= 1'b0;
            id_ex       <= '0;
        end else if (!mem_stall) begin
            if_id_valid    <= 1'b1;
            if_id_pc       <= pc;
            if_id_inst     <= imem_data;
            id_ex.valid    <= if_id_valid;
            id_ex.pc       <= if_id_pc;
            id_ex.dec      <= id_dec;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
        end
    end

    assign alu_b = id_ex.dec.use_imm ? id_ex.dec.imm : id_ex.rs2_data;

    ex_alu u_alu (
        .a(id_ex.rs1_data),
        .b(alu_b),
        .op(id_ex.dec.alu_op),
        .result(alu_result)
    );

    ex_branch u_branch (
        .ex(id_ex),
        .taken(taken),
        .target(br_target),
        .link(link)
    );

    mem_access u_mem (
        .clk(clk),
        .rst(rst),
        .ex(id_ex),
        .dmem_req(dmem_req),
        .dmem_cmd(dmem_cmd),
        .dmem_rdata(dmem_rdata),
        .dmem_ready(dmem_ready),
        .mem_stall(mem_stall),
        .load_valid(load_valid),
        .load_data(load_data)
    );

    // a load retires only in MEM_DONE
    assign wb_en = id_ex.valid && id_ex.dec.writes_rd && !mem_stall;
    assign wb_rd = id_ex.dec.rd;

    always_comb begin
        if (load_valid) begin
            wb_data = load_data;
        end else if (id_ex.dec.is_jal) begin
            wb_data = link;
        end else begin
            wb_data = alu_result;
        end
    end

endmodule

// File: cpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the three-stage core
// widths, vector types, ALU and memory FSM enums
// decoded fields, ID/EX contents, data port command
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpu_pkg;

    // data path and register index widths
    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           inst_t;

    // PASS_B forwards the immediate for LUI
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_t;

    // data memory access phases
    typedef enum logic [1:0] {
        MEM_IDLE = 2'd0,
        MEM_BUSY = 2'd1,
        MEM_DONE = 2'd2
    } mem_state_t;

    // all flags clear means no-op
    typedef struct packed {
        alu_op_t   alu_op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
        logic      use_imm;
        logic      writes_rd;
        logic      is_load;
        logic      is_store;
        logic      is_beq;
        logic      is_bne;
        logic      is_jal;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        decoded_t dec;
        xlen_t    rs1_data;
        xlen_t    rs2_data;
    } id_ex_t;

    // word access only, we high for a store
    typedef struct packed {
        logic  we;
        xlen_t addr;
        xlen_t wdata;
    } dmem_cmd_t;

endpackage

// File: ex_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage ALU for register and immediate forms
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module ex_alu (
    input  cpu_pkg::xlen_t   a,
    input  cpu_pkg::xlen_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::xlen_t   result
);
    import cpu_pkg::*;

    logic less_signed;

    // signed compare for SLT
    assign less_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, less_signed};
            end
            ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: ex_branch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch unit, BEQ/BNE compare and JAL
// jump target and link value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module ex_branch (
    input  cpu_pkg::id_ex_t ex,
    output logic            taken,
    output cpu_pkg::xlen_t  target,
    output cpu_pkg::xlen_t  link
);
    import cpu_pkg::*;

    logic operands_equal;
    logic cond_met;

    assign operands_equal = (ex.rs1_data == ex.rs2_data);

    // JAL always jumps, branches on the compare
    assign cond_met = (ex.dec.is_beq && operands_equal)
                   || (ex.dec.is_bne && !operands_equal)
                   || ex.dec.is_jal;

    // bubbles never redirect fetch
    assign taken = ex.valid && cond_met;

    assign target = ex.pc + ex.dec.imm;
    assign link   = ex.pc + XLEN'(4);

endmodule

// File: inst_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I subset decoder
// ALU op select, immediate extension, instruction flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module inst_decoder (
    input  cpu_pkg::inst_t    inst,
    output cpu_pkg::decoded_t dec
);
    import cpu_pkg::*;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // sign-extended immediates, one per format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.alu_op = ALU_ADD;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        case (opcode)
            OP_REG: begin
                dec.writes_rd = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: dec.alu_op = ALU_ADD;
                    {F7_ALT, 3'b000}:  dec.alu_op = ALU_SUB;
                    {F7_BASE, 3'b111}: dec.alu_op = ALU_AND;
                    {F7_BASE, 3'b110}: dec.alu_op = ALU_OR;
                    {F7_BASE, 3'b100}: dec.alu_op = ALU_XOR;
                    {F7_BASE, 3'b010}: dec.alu_op = ALU_SLT;
                    default:           dec.writes_rd = 1'b0;
                endcase
            end
            OP_IMM: begin
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = ALU_ADD;
                    3'b111:  dec.alu_op = ALU_AND;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b100:  dec.alu_op = ALU_XOR;
                    // SLTI and shifts fall outside the subset
                    default: begin
                        dec.use_imm   = 1'b0;
                        dec.writes_rd = 1'b0;
                    end
                endcase
            end
            OP_LUI: begin
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
                dec.alu_op    = ALU_PASS_B;
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec.imm       = imm_i;
                    dec.use_imm   = 1'b1;
                    dec.is_load   = 1'b1;
                    dec.writes_rd = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin
                    dec.imm      = imm_s;
                    dec.use_imm  = 1'b1;
                    dec.is_store = 1'b1;
                end
            end
            OP_BRANCH: begin
                dec.imm    = imm_b;
                dec.is_beq = (funct3 == 3'b000);
                dec.is_bne = (funct3 == 3'b001);
            end
            OP_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            default: begin
                // unknown encoding, leave as a bubble
                dec.imm = '0;
            end
        endcase
    end

endmodule

// File: inst_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch program counter
// holds on stall, steps by four, loads jump target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module inst_fetch #(
    parameter cpu_pkg::xlen_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           jump_en,
    input  cpu_pkg::xlen_t jump_target,
    output cpu_pkg::xlen_t pc
);
    import cpu_pkg::*;

    xlen_t pc_next;

    // a taken branch in EX wins over a memory stall
    always_comb begin
        if (jump_en) begin
            pc_next = jump_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: mem_access.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory access FSM
// request/ready handshake, load capture, stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mem_access (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::id_ex_t    ex,
    output logic               dmem_req,
    output cpu_pkg::dmem_cmd_t dmem_cmd,
    input  cpu_pkg::xlen_t     dmem_rdata,
    input  logic               dmem_ready,
    output logic               mem_stall,
    output logic               load_valid,
    output cpu_pkg::xlen_t     load_data
);
    import cpu_pkg::*;

    mem_state_t state;
    mem_state_t state_next;
    logic       is_mem;

    assign is_mem = ex.valid && (ex.dec.is_load || ex.dec.is_store);

    always_comb begin
        state_next = state;
        case (state)
            MEM_IDLE: begin
                if (is_mem) begin
                    state_next = MEM_BUSY;
                end
            end
            MEM_BUSY: begin
                if (dmem_ready) begin
                    state_next = MEM_DONE;
                end
            end
            // one cycle for write-back, then back to idle
            MEM_DONE: begin
                state_next = MEM_IDLE;
            end
            default: begin
                state_next = MEM_IDLE;
            end
        endcase
    end

    // request is high exactly while busy
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= MEM_IDLE;
            dmem_req <= 1'b0;
        end else begin
            state    <= state_next;
            dmem_req <= (state_next == MEM_BUSY);
        end
    end

    // command fixed at issue, held until ready
    always_ff @(posedge clk) begin
        if (state == MEM_IDLE && is_mem) begin
            dmem_cmd.we    <= ex.dec.is_store;
            dmem_cmd.addr  <= ex.rs1_data + ex.dec.imm;
            dmem_cmd.wdata <= ex.rs2_data;
        end
        if (state == MEM_BUSY && dmem_ready) begin
            load_data <= dmem_rdata;
        end
    end

    assign mem_stall  = is_mem && (state == MEM_IDLE || state == MEM_BUSY);
    assign load_valid = (state == MEM_DONE) && ex.dec.is_load;

endmodule

// File: registers.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32-entry register file, x0 reads zero
// same-cycle write-through on both read ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module registers (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::xlen_t    rs1_data,
    output cpu_pkg::xlen_t    rs2_data,
    input  logic              wb_en,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  cpu_pkg::xlen_t    wb_data
);
    import cpu_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    xlen_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // the value being written this cycle bypasses the array
    assign rs1_data = (rs1 == '0) ? '0
                    : (wb_en && wb_rd == rs1) ? wb_data
                    : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0
                    : (wb_en && wb_rd == rs2) ? wb_data
                    : regs[rs2];

endmodule

// File: tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

// File: tb_cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top for the three-stage core
// instruction and data memory models, encoders,
// compare tasks, directed tests, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_cpu;
    import cpu_pkg::*;

    localparam xlen_t      RESET_PC      = 32'h40;
    localparam int         IMEM_WORDS    = 64;
    localparam int         DMEM_WORDS    = 512;
    localparam int         RESET_CYCLES  = 5;
    localparam int         SETTLE_CYCLES = 20;
    localparam int         MAX_LAT       = 5;
    // upper bound on words emitted over all tests
    localparam int         TOTAL_WORDS   = 96;
    localparam int         WATCHDOG      = TOTAL_WORDS * (2 + MAX_LAT) + 5 * 25 + 200;
    localparam logic [6:0] OPC_IMM       = 7'b0010011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] F7_SUB        = 7'b0100000;

    logic      clk;
    logic      rst;
    xlen_t     imem_addr;
    inst_t     imem_data;
    logic      dmem_req;
    dmem_cmd_t dmem_cmd;
    xlen_t     dmem_rdata;
    logic      dmem_ready;

    inst_t     imem [IMEM_WORDS];
    xlen_t     dmem [DMEM_WORDS];
    dmem_cmd_t expected[$];
    int        emit_idx;
    xlen_t     rng;
    logic      counting;
    int        wait_left;

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk(clk));

    cpu_pipeline #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk),
        .rst(rst),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .dmem_req(dmem_req),
        .dmem_cmd(dmem_cmd),
        .dmem_rdata(dmem_rdata),
        .dmem_ready(dmem_ready)
    );

    // combinational instruction port
    assign imem_data = imem[imem_addr[7:2]];

    function automatic xlen_t xorshift32(input xlen_t x);
        xlen_t s;
        s = x;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic xlen_t fill_word(input xlen_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_5a5a;
    endfunction

    function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic inst_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                    input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic inst_t enc_sw(input int rs2, input int rs1, input int imm);
        logic [11:0] i12;
        i12 = 12'(imm);
        return {i12[11:5], 5'(rs2), 5'(rs1), 3'b010, i12[4:0], 7'b0100011};
    endfunction

    function automatic inst_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                    input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic inst_t enc_jal(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic abort_run(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_cmd(input string name, input dmem_cmd_t got, input dmem_cmd_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got we=%b addr=%h wdata=%h",
                     $time, name, got.we, got.addr, got.wdata,
                     " expected we=%b addr=%h wdata=%h", exp.we, exp.addr, exp.wdata);
            $display("SIMULATION FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic emit(input inst_t word);
        imem[emit_idx] = word;
        emit_idx++;
    endtask

    task automatic expect_store(input xlen_t addr, input xlen_t data);
        dmem_cmd_t c;
        c.we    = 1'b1;
        c.addr  = addr;
        c.wdata = data;
        expected.push_back(c);
    endtask

    // finish the handshake: check a store, answer a load
    task automatic serve_request();
        if (dmem_cmd.we) begin
            if (expected.size() == 0) begin
                abort_run("store seen at the data port when none was expected");
            end
            check_cmd("dmem_cmd", dmem_cmd, expected.pop_front());
            dmem[dmem_cmd.addr[10:2]] = dmem_cmd.wdata;
        end
        dmem_rdata = dmem[dmem_cmd.addr[10:2]];
        dmem_ready = 1'b1;
    endtask

    // data memory, 0 to 5 cycles of random latency
    always @(negedge clk) begin
        if (!rst || dmem_ready) begin
            dmem_ready = 1'b0;
            counting   = 1'b0;
        end else if (dmem_req) begin
            if (!counting) begin
                counting  = 1'b1;
                rng       = xorshift32(rng);
                wait_left = int'(rng % (MAX_LAT + 1));
            end
            if (wait_left == 0) begin
                serve_request();
            end else begin
                wait_left--;
            end
        end
    end

    always @(negedge clk) begin
        if (DUT.u_assert.fail_count != 0) begin
            abort_run("a port assertion on the core failed");
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        abort_run("watchdog expired before all expected stores were seen");
    end

    task automatic begin_test(input string name);
        @(negedge clk);
        rst = 1'b0;
        $display("test: %s", name);
        expected.delete();
        emit_idx = int'(RESET_PC[7:2]);
        // unknown opcode zero in every unused word
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = inst_t'(i << 9);
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(xlen_t'(i << 2));
        end
        repeat (RESET_CYCLES) @(negedge clk);
    endtask

    // self loop at the end, then leave reset
    task automatic release_reset();
        emit(enc_jal(0, 0));
        rst = 1'b1;
        check_word("imem_addr", imem_addr, RESET_PC);
    endtask

    task automatic wait_stores();
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    task automatic test_reset_state();
        begin_test("reset state");
        emit(enc_i(OPC_IMM, 3'b000, 1, 0, 5));
        emit(enc_i(OPC_IMM, 3'b000, 2, 1, 6));
        emit(enc_r(7'b0, 3'b000, 3, 1, 2));
        emit(enc_sw(3, 0, 'h80));
        expect_store('h80, 32'd5 + (32'd5 + 32'd6));
        release_reset();
        // store reaches EX after five edges, request follows one later
        repeat (5) begin
            @(negedge clk);
            check_flag("dmem_req", dmem_req, 1'b0);
        end
        wait_stores();
    endtask

    task automatic test_alu_forwarding();
        xlen_t v [13];
        begin_test("alu forwarding");
        v[1]  = 32'd7;
        v[2]  = v[1] + xlen_t'(-12);
        v[3]  = v[1] + v[2];
        v[4]  = v[3] - v[2];
        v[5]  = xlen_t'($signed(v[2]) < $signed(v[1]));
        v[6]  = v[4] ^ v[2];
        v[7]  = v[6] & v[4];
        v[8]  = v[7] | v[5];
        v[9]  = {20'h12345, 12'h000} | 32'h678;
        v[10] = v[9] ^ xlen_t'(-1);
        v[11] = v[10] & 32'h0f0;
        v[12] = xlen_t'($signed(v[1]) < $signed(v[2]));
        emit(enc_i(OPC_IMM, 3'b000, 1, 0, 7));
        emit(enc_i(OPC_IMM, 3'b000, 2, 1, -12));
        emit(enc_r(7'b0, 3'b000, 3, 1, 2));
        emit(enc_r(F7_SUB, 3'b000, 4, 3, 2));
        emit(enc_r(7'b0, 3'b010, 5, 2, 1));
        emit(enc_r(7'b0, 3'b100, 6, 4, 2));
        emit(enc_r(7'b0, 3'b111, 7, 6, 4));
        emit(enc_r(7'b0, 3'b110, 8, 7, 5));
        emit({20'h12345, 5'd9, 7'b0110111});
        emit(enc_i(OPC_IMM, 3'b110, 9, 9, 'h678));
        emit(enc_i(OPC_IMM, 3'b100, 10, 9, -1));
        emit(enc_i(OPC_IMM, 3'b111, 11, 10, 'h0f0));
        emit(enc_r(7'b0, 3'b010, 12, 1, 2));
        for (int r = 3; r <= 12; r++) begin
            emit(enc_sw(r, 0, 'h100 + 4 * (r - 3)));
            expect_store('h100 + 4 * (r - 3), v[r]);
        end
        release_reset();
        wait_stores();
    endtask

    task automatic test_branch_flush();
        begin_test("branch flush");
        emit(enc_i(OPC_IMM, 3'b000, 1, 0, 3));
        emit(enc_i(OPC_IMM, 3'b000, 2, 0, 3));
        // taken BEQ skips two stores
        emit(enc_b(3'b000, 1, 2, 12));
        emit(enc_sw(1, 0, 'h200));
        emit(enc_sw(2, 0, 'h204));
        emit(enc_b(3'b001, 1, 2, 12));
        emit(enc_i(OPC_IMM, 3'b000, 3, 0, 9));
        emit(enc_jal(4, 12));
        emit(enc_sw(3, 0, 'h208));
        emit(enc_sw(3, 0, 'h20c));
        emit(enc_sw(3, 0, 'h210));
        emit(enc_sw(4, 0, 'h214));
        expect_store('h210, 32'd9);
        // link of the JAL at word 7
        expect_store('h214, RESET_PC + 4 * 7 + 4);
        release_reset();
        wait_stores();
    endtask

    task automatic test_load_use();
        xlen_t v1;
        begin_test("load use");
        v1 = {20'hcafe0, 12'h000} + 32'h123;
        emit({20'hcafe0, 5'd1, 7'b0110111});
        emit(enc_i(OPC_IMM, 3'b000, 1, 1, 'h123));
        emit(enc_sw(1, 0, 'h300));
        emit(enc_i(OPC_LOAD, 3'b010, 2, 0, 'h300));
        emit(enc_r(7'b0, 3'b000, 3, 2, 1));
        emit(enc_sw(3, 0, 'h304));
        emit(enc_i(OPC_LOAD, 3'b010, 4, 0, 'h308));
        emit(enc_r(7'b0, 3'b000, 5, 4, 1));
        emit(enc_sw(5, 0, 'h30c));
        expect_store('h300, v1);
        expect_store('h304, v1 + v1);
        expect_store('h30c, fill_word('h308) + v1);
        release_reset();
        wait_stores();
    endtask

    task automatic test_random_latency();
        xlen_t acc;
        xlen_t ld;
        begin_test("random latency");
        acc = 32'd1;
        emit(enc_i(OPC_IMM, 3'b000, 1, 0, 1));
        for (int k = 0; k < 8; k++) begin
            ld = fill_word('h400 + 8 * k);
            emit(enc_i(OPC_LOAD, 3'b010, 2, 0, 'h400 + 8 * k));
            // odd rounds mix with XOR instead of ADD
            if (k % 2 == 1) begin
                emit(enc_r(7'b0, 3'b100, 1, 1, 2));
                acc = acc ^ ld;
            end else begin
                emit(enc_r(7'b0, 3'b000, 1, 1, 2));
                acc = acc + ld;
            end
            emit(enc_sw(1, 0, 'h404 + 8 * k));
            expect_store('h404 + 8 * k, acc);
        end
        release_reset();
        wait_stores();
    endtask

    initial begin
        rst        = 1'b0;
        dmem_ready = 1'b0;
        dmem_rdata = '0;
        rng        = 32'd79;
        counting   = 1'b0;
        wait_left  = 0;
        emit_idx   = 0;
        test_reset_state();
        test_alu_forwarding();
        test_branch_flush();
        test_load_use();
        test_random_latency();
        if (DUT.u_assert.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "port assertions failed");
        end
    end

endmodule
